/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock_o,
	output logic rst_n_o
);

	localparam time HALF_PERIOD = 4ns;
	localparam int  RESET_CYCLES = 8;

	initial begin
		clock_o = 1'b0;
		forever #(HALF_PERIOD) clock_o = ~clock_o;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

/* sim/tb_mem_fabric.sv */
`timescale 1ns/1ps

module tb_mem_fabric;

	import bus_pkg::*;
	import soc_map_pkg::*;

	localparam int NUM_ROWS = 12;
	localparam int TIMEOUT  = 200;

	typedef enum logic {
		PORT_FETCH,
		PORT_DATA
	} port_e;

	typedef enum logic {
		CHK_EXACT,
		// clint low word, compared with the previous read
		CHK_RISE
	} chk_e;

	typedef struct packed {
		port_e      port;
		chk_e       kind;
		bus_req_t   req;
		bus_resp_t  exp;
		logic       has_byte;
		uart_byte_t exp_byte;
	} row_t;

	logic              clock;
	logic              rst_n;
	logic              fetch_req_valid;
	fetch_req_t        fetch_req;
	logic              fetch_req_ready;
	logic              fetch_resp_valid;
	bus_resp_t         fetch_resp;
	logic              fetch_resp_ready;
	logic              data_req_valid;
	bus_req_t          data_req;
	logic              data_req_ready;
	logic              data_resp_valid;
	bus_resp_t         data_resp;
	logic              data_resp_ready;
	logic              uart_tx_valid;
	uart_byte_t        uart_tx_byte;
	logic              uart_tx_ready;

	row_t              rows [NUM_ROWS];
	string             row_name [NUM_ROWS];
	logic [31:0]       rng_q;
	logic [DATA_W-1:0] last_low;

	tb_clock_gen u_tb_clock_gen (
		.clock_o (clock),
		.rst_n_o (rst_n)
	);

	mem_fabric_top u_mem_fabric_top (
		.clock              (clock),
		.rst_n_i            (rst_n),
		.fetch_req_valid_i  (fetch_req_valid),
		.fetch_req_i        (fetch_req),
		.fetch_req_ready_o  (fetch_req_ready),
		.fetch_resp_valid_o (fetch_resp_valid),
		.fetch_resp_o       (fetch_resp),
		.fetch_resp_ready_i (fetch_resp_ready),
		.data_req_valid_i   (data_req_valid),
		.data_req_i         (data_req),
		.data_req_ready_o   (data_req_ready),
		.data_resp_valid_o  (data_resp_valid),
		.data_resp_o        (data_resp),
		.data_resp_ready_i  (data_resp_ready),
		.uart_tx_valid_o    (uart_tx_valid),
		.uart_tx_byte_o     (uart_tx_byte),
		.uart_tx_ready_i    (uart_tx_ready)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// strobed bytes come from wdata, the rest stay
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (wdata & mask);
	endfunction

	function automatic bus_req_t make_req(input logic [31:0] addr, input logic wr,
			input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
		bus_req_t r;
		r.addr  = addr;
		r.write = wr;
		r.wdata = wdata;
		r.strb  = strb;
		return r;
	endfunction

	function automatic bus_resp_t make_resp(input logic [DATA_W-1:0] rdata,
			input bus_resp_code_e code);
		bus_resp_t r;
		r.rdata = rdata;
		r.resp  = code;
		return r;
	endfunction

	function automatic logic resp_valid_of(input port_e port);
		return (port == PORT_DATA) ? data_resp_valid : fetch_resp_valid;
	endfunction

	function automatic bus_resp_t resp_of(input port_e port);
		return (port == PORT_DATA) ? data_resp : fetch_resp;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic drive_resp_ready(input port_e port, input logic value);
		if (port == PORT_DATA) begin
			data_resp_ready = value;
		end else begin
			fetch_resp_ready = value;
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic check_resp(input string name, input bus_resp_t exp, input bus_resp_t act);
		if (act !== exp) begin
			stop_run($sformatf("CHECK FAILED %s: expected rdata %h resp %0d, actual rdata %h resp %0d",
				name, exp.rdata, exp.resp, act.rdata, act.resp));
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_ports_blocked(input string name);
		if (fetch_req_ready || data_req_ready) begin
			stop_run({name, ": a request port was ready while a response was pending"});
		end
	endtask

	// ----------------------------------------
	// stimulus table
	// ----------------------------------------
	function automatic void build_table();
		logic [DATA_W-1:0] w_full;
		logic [DATA_W-1:0] w_part;
		w_full = merge_bytes('0, 32'h11223344, 4'hf);
		w_part = merge_bytes(w_full, 32'haabbccdd, 4'b0101);
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r] = '0;
			rows[r].exp = make_resp('0, RESP_OKAY);
		end
		row_name[0]  = "sram full write";
		rows[0].port = PORT_DATA;
		rows[0].req  = make_req({SRAM_PAGE, 12'h010}, 1'b1, 32'h11223344, 4'hf);
		rows[0].exp  = make_resp(w_full, RESP_OKAY);
		row_name[1]  = "sram partial write";
		rows[1].port = PORT_DATA;
		rows[1].req  = make_req({SRAM_PAGE, 12'h010}, 1'b1, 32'haabbccdd, 4'b0101);
		rows[1].exp  = make_resp(w_part, RESP_OKAY);
		row_name[2]  = "sram fetch readback";
		rows[2].port = PORT_FETCH;
		rows[2].req  = make_req({SRAM_PAGE, 12'h010}, 1'b0, '0, '0);
		rows[2].exp  = make_resp(w_part, RESP_OKAY);
		// unpopulated top of the sram page
		row_name[3]  = "decerr sram hole";
		rows[3].port = PORT_DATA;
		rows[3].req  = make_req({SRAM_PAGE, 12'(SRAM_BYTES)}, 1'b0, '0, '0);
		rows[3].exp  = make_resp('0, RESP_DECERR);
		row_name[4]  = "decerr fetch other page";
		rows[4].port = PORT_FETCH;
		rows[4].req  = make_req(32'h12345100, 1'b0, '0, '0);
		rows[4].exp  = make_resp('0, RESP_DECERR);
		row_name[5]  = "decerr data write";
		rows[5].port = PORT_DATA;
		rows[5].req  = make_req(32'h40000000, 1'b1, 32'hdeadbeef, 4'hf);
		rows[5].exp  = make_resp('0, RESP_DECERR);
		row_name[6]  = "sram after faults";
		rows[6].port = PORT_DATA;
		rows[6].req  = make_req({SRAM_PAGE, 12'h010}, 1'b0, '0, '0);
		rows[6].exp  = make_resp(w_part, RESP_OKAY);
		row_name[7]      = "uart write lane0";
		rows[7].port     = PORT_DATA;
		rows[7].req      = make_req({IO_PAGE, UART_OFFSET}, 1'b1, 32'h5a5a5a41, 4'h1);
		rows[7].has_byte = 1'b1;
		rows[7].exp_byte = 8'h41;
		row_name[8]      = "uart write full word";
		rows[8].port     = PORT_DATA;
		rows[8].req      = make_req({IO_PAGE, UART_OFFSET}, 1'b1, 32'h1234567e, 4'hf);
		rows[8].has_byte = 1'b1;
		rows[8].exp_byte = 8'h7e;
		row_name[9]   = "clint low first";
		rows[9].port  = PORT_DATA;
		rows[9].kind  = CHK_RISE;
		rows[9].req   = make_req({IO_PAGE, CLINT_OFFSET}, 1'b0, '0, '0);
		row_name[10]  = "clint low second";
		rows[10].port = PORT_FETCH;
		rows[10].kind = CHK_RISE;
		rows[10].req  = make_req({IO_PAGE, CLINT_OFFSET}, 1'b0, '0, '0);
		// high word stays zero this early after reset
		row_name[11]  = "clint high";
		rows[11].port = PORT_DATA;
		rows[11].req  = make_req({IO_PAGE, CLINT_OFFSET + 12'h004}, 1'b0, '0, '0);
	endfunction

	// ----------------------------------------
	// port handshakes
	// ----------------------------------------
	task automatic send_request(input port_e port, input bus_req_t req, input string name);
		int   waited;
		logic taken;
		waited = 0;
		taken  = 1'b0;
		if (port == PORT_DATA) begin
			data_req       = req;
			data_req_valid = 1'b1;
		end else begin
			fetch_req       = '{addr: req.addr};
			fetch_req_valid = 1'b1;
		end
		while (!taken) begin
			#1;
			taken = (port == PORT_DATA) ? data_req_ready : fetch_req_ready;
			next_cycle();
			waited++;
			if (!taken && waited > TIMEOUT) begin
				stop_run({name, ": request was never accepted"});
			end
		end
		data_req_valid  = 1'b0;
		fetch_req_valid = 1'b0;
	endtask

	task automatic wait_response(input int r);
		row_t      row;
		string     name;
		int        waited;
		int        stall;
		int        hold;
		int        tx_count;
		logic      seen;
		bus_resp_t first;
		row      = rows[r];
		name     = row_name[r];
		waited   = 0;
		tx_count = 0;
		seen     = 1'b0;
		rng_q    = xorshift(rng_q);
		stall    = 1 + rng_q % 5;
		rng_q    = xorshift(rng_q);
		hold     = rng_q % 5;
		while (!seen) begin
			// hold the stream off for a few cycles once the byte is offered
			if (row.has_byte) begin
				uart_tx_ready = (stall == 0);
				if (stall > 0 && uart_tx_valid) begin
					stall--;
				end
			end
			#1;
			if (uart_tx_valid && uart_tx_ready) begin
				check_byte(name, row.exp_byte, uart_tx_byte);
				tx_count++;
			end
			seen = resp_valid_of(row.port);
			if (!seen) begin
				next_cycle();
				waited++;
				if (waited > TIMEOUT) begin
					stop_run({name, ": no response arrived"});
				end
			end
		end
		uart_tx_ready = 1'b0;
		// write ack must trail the byte
		check_word({name, " bytes sent"}, row.has_byte ? 32'd1 : 32'd0, 32'(tx_count));
		check_ports_blocked(name);
		first = resp_of(row.port);
		if (row.kind == CHK_RISE) begin
			if (first.rdata <= last_low) begin
				stop_run($sformatf("CHECK FAILED %s: expected above %h, actual %h",
					name, last_low, first.rdata));
			end
			check_word({name, " code"}, 32'(RESP_OKAY), 32'(first.resp));
			last_low = first.rdata;
		end else begin
			check_resp(name, row.exp, first);
		end
		for (int i = 0; i < hold; i++) begin
			next_cycle();
			if (!resp_valid_of(row.port)) begin
				stop_run({name, ": response valid dropped before it was accepted"});
			end
			check_resp({name, " held"}, first, resp_of(row.port));
			check_ports_blocked(name);
		end
		next_cycle();
		drive_resp_ready(row.port, 1'b1);
		#1;
		if (!resp_valid_of(row.port)) begin
			stop_run({name, ": response valid dropped before it was accepted"});
		end
		next_cycle();
		drive_resp_ready(row.port, 1'b0);
		if (uart_tx_valid) begin
			stop_run({name, ": an extra byte is waiting on the uart stream"});
		end
	endtask

	// data write and fetch read of the same word, raised together
	task automatic run_simultaneous();
		bus_req_t  wr;
		bus_resp_t exp;
		int        waited;
		logic      data_done;
		logic      fetch_done;
		logic      data_taken;
		logic      fetch_taken;
		wr         = make_req({SRAM_PAGE, 12'h020}, 1'b1, 32'hcafef00d, 4'hf);
		exp        = make_resp(merge_bytes('0, wr.wdata, wr.strb), RESP_OKAY);
		waited     = 0;
		data_done  = 1'b0;
		fetch_done = 1'b0;
		data_req         = wr;
		data_req_valid   = 1'b1;
		fetch_req        = '{addr: wr.addr};
		fetch_req_valid  = 1'b1;
		data_resp_ready  = 1'b1;
		fetch_resp_ready = 1'b1;
		while (!(data_done && fetch_done)) begin
			#1;
			// a request counts as taken at the coming edge
			data_taken  = data_req_valid && data_req_ready;
			fetch_taken = fetch_req_valid && fetch_req_ready;
			if (data_resp_valid) begin
				check_resp("simultaneous data", exp, data_resp);
				data_done = 1'b1;
			end
			if (fetch_resp_valid) begin
				if (!data_done) begin
					stop_run("simultaneous: fetch response came before the data response");
				end
				check_resp("simultaneous fetch", exp, fetch_resp);
				fetch_done = 1'b1;
			end
			next_cycle();
			if (data_taken) begin
				data_req_valid = 1'b0;
			end
			if (fetch_taken) begin
				fetch_req_valid = 1'b0;
			end
			waited++;
			if (waited > TIMEOUT) begin
				stop_run("simultaneous: both requests did not complete");
			end
		end
		data_resp_ready  = 1'b0;
		fetch_resp_ready = 1'b0;
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int waited;
		fetch_req_valid  = 1'b0;
		fetch_req        = '0;
		fetch_resp_ready = 1'b0;
		data_req_valid   = 1'b0;
		data_req         = '0;
		data_resp_ready  = 1'b0;
		uart_tx_ready    = 1'b0;
		rng_q            = 32'd96;
		last_low         = '0;
		waited           = 0;
		build_table();
		while (rst_n !== 1'b1) begin
			@(posedge clock);
			waited++;
			if (waited > TIMEOUT) begin
				stop_run("reset was never released");
			end
		end
		next_cycle();
		// resp valids and uart valid low, both readies high
		check_word("reset state", 32'h3, 32'({fetch_resp_valid, data_resp_valid,
			uart_tx_valid, fetch_req_ready, data_req_ready}));
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_request(rows[r].port, rows[r].req, row_name[r]);
			wait_response(r);
		end
		run_simultaneous();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* verilog.f */
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/bus_arbiter.sv
verilog/addr_xbar.sv
verilog/sram_target.sv
verilog/clint_timer.sv
verilog/uart_tx_target.sv
verilog/mem_fabric_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_fabric.sv

/* verilog/addr_xbar.sv */
`timescale 1ns/1ps

module addr_xbar (
	input  logic               clock,
	input  logic               rst_n_i,
	// upstream from the arbiter
	input  logic               up_req_valid_i,
	input  bus_pkg::bus_req_t  up_req_i,
	output logic               up_req_ready_o,
	output logic               up_resp_valid_o,
	output bus_pkg::bus_resp_t up_resp_o,
	input  logic               up_resp_ready_i,
	// sram target
	output logic               sram_req_valid_o,
	output bus_pkg::bus_req_t  sram_req_o,
	input  logic               sram_rsp_valid_i,
	input  bus_pkg::bus_resp_t sram_rsp_i,
	// uart target
	output logic               uart_req_valid_o,
	output bus_pkg::bus_req_t  uart_req_o,
	input  logic               uart_rsp_valid_i,
	input  bus_pkg::bus_resp_t uart_rsp_i,
	// clint target
	output logic               clint_req_valid_o,
	output bus_pkg::bus_req_t  clint_req_o,
	input  logic               clint_rsp_valid_i,
	input  bus_pkg::bus_resp_t clint_rsp_i
);

	import bus_pkg::*;
	import soc_map_pkg::*;

	target_sel_e sel_d;
	target_sel_e sel_q;
	logic        busy_q;
	logic        pulse_q;
	bus_req_t    req_q;
	logic        resp_valid_q;
	bus_resp_t   resp_q;
	logic        tgt_rsp_valid;
	bus_resp_t   tgt_rsp;
	logic        up_req_fire;
	logic        up_resp_fire;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	always_comb begin
		sel_d = TGT_NONE;
		if (up_req_i.addr.map.page == SRAM_PAGE) begin
			// upper part of the sram page is unpopulated
			if (up_req_i.addr.map.offset < 12'(SRAM_BYTES)) begin
				sel_d = TGT_SRAM;
			end
		end else if (up_req_i.addr.map.page == IO_PAGE) begin
			if (up_req_i.addr.map.offset[11:2] == UART_OFFSET[11:2]) begin
				sel_d = TGT_UART;
			end else if (up_req_i.addr.map.offset[11:3] == CLINT_OFFSET[11:3]) begin
				// both halves of mtime
				sel_d = TGT_CLINT;
			end
		end
	end

	assign up_req_ready_o = !busy_q;
	assign up_req_fire    = up_req_valid_i && up_req_ready_o;
	assign up_resp_fire   = resp_valid_q && up_resp_ready_i;

	// ----------------------------------------
	// target side
	// ----------------------------------------
	assign sram_req_valid_o  = pulse_q && (sel_q == TGT_SRAM);
	assign uart_req_valid_o  = pulse_q && (sel_q == TGT_UART);
	assign clint_req_valid_o = pulse_q && (sel_q == TGT_CLINT);
	assign sram_req_o        = req_q;
	assign uart_req_o        = req_q;
	assign clint_req_o       = req_q;

	// response from the remembered target
	always_comb begin
		tgt_rsp_valid = 1'b0;
		tgt_rsp       = sram_rsp_i;
		case (sel_q)
			TGT_SRAM: begin
				tgt_rsp_valid = sram_rsp_valid_i;
				tgt_rsp       = sram_rsp_i;
			end
			TGT_UART: begin
				tgt_rsp_valid = uart_rsp_valid_i;
				tgt_rsp       = uart_rsp_i;
			end
			TGT_CLINT: begin
				tgt_rsp_valid = clint_rsp_valid_i;
				tgt_rsp       = clint_rsp_i;
			end
			default: begin
				tgt_rsp_valid = 1'b0;
			end
		endcase
	end

	assign up_resp_valid_o = resp_valid_q;
	assign up_resp_o       = resp_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q       <= 1'b0;
			pulse_q      <= 1'b0;
			sel_q        <= TGT_NONE;
			resp_valid_q <= 1'b0;
		end else begin
			pulse_q <= up_req_fire && (sel_d != TGT_NONE);
			if (up_req_fire) begin
				busy_q <= 1'b1;
				sel_q  <= sel_d;
			end else if (up_resp_fire) begin
				busy_q <= 1'b0;
			end
			// decode error is answered here, no target involved
			if (up_req_fire && (sel_d == TGT_NONE)) begin
				resp_valid_q <= 1'b1;
			end else if (busy_q && tgt_rsp_valid) begin
				resp_valid_q <= 1'b1;
			end else if (up_resp_fire) begin
				resp_valid_q <= 1'b0;
			end
		end
	end

	// request and response buffers
	always_ff @(posedge clock) begin
		if (up_req_fire) begin
			req_q <= up_req_i;
		end
		if (up_req_fire && (sel_d == TGT_NONE)) begin
			resp_q <= '{rdata: '0, resp: RESP_DECERR};
		end else if (busy_q && tgt_rsp_valid) begin
			resp_q <= tgt_rsp;
		end
	end

endmodule

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                clock,
	input  logic                rst_n_i,
	// fetch port
	input  logic                fetch_req_valid_i,
	input  bus_pkg::fetch_req_t fetch_req_i,
	output logic                fetch_req_ready_o,
	output logic                fetch_resp_valid_o,
	output bus_pkg::bus_resp_t  fetch_resp_o,
	input  logic                fetch_resp_ready_i,
	// data port
	input  logic                data_req_valid_i,
	input  bus_pkg::bus_req_t   data_req_i,
	output logic                data_req_ready_o,
	output logic                data_resp_valid_o,
	output bus_pkg::bus_resp_t  data_resp_o,
	input  logic                data_resp_ready_i,
	// merged stream towards the crossbar
	output logic                bus_req_valid_o,
	output bus_pkg::bus_req_t   bus_req_o,
	input  logic                bus_req_ready_i,
	input  logic                bus_resp_valid_i,
	input  bus_pkg::bus_resp_t  bus_resp_i,
	output logic                bus_resp_ready_o
);

	import bus_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DATA
	} arb_state_e;

	arb_state_e state_q;
	logic       req_valid_q;
	bus_req_t   req_q;
	bus_req_t   fetch_as_bus;
	logic       fetch_fire;
	logic       data_fire;
	logic       resp_fire;

	// ----------------------------------------
	// request side
	// ----------------------------------------
	// data port has priority over fetch
	assign data_req_ready_o  = (state_q == ST_IDLE);
	assign fetch_req_ready_o = (state_q == ST_IDLE) && !data_req_valid_i;

	assign data_fire  = data_req_valid_i && data_req_ready_o;
	assign fetch_fire = fetch_req_valid_i && fetch_req_ready_o;

	// a fetch is a plain word read
	assign fetch_as_bus = '{
		addr:  fetch_req_i.addr,
		write: 1'b0,
		wdata: '0,
		strb:  '0
	};

	assign bus_req_valid_o = req_valid_q;
	assign bus_req_o       = req_q;

	// ----------------------------------------
	// response side
	// ----------------------------------------
	always_comb begin
		case (state_q)
			ST_FETCH: bus_resp_ready_o = fetch_resp_ready_i;
			ST_DATA:  bus_resp_ready_o = data_resp_ready_i;
			default:  bus_resp_ready_o = 1'b0;
		endcase
	end

	assign resp_fire = bus_resp_valid_i && bus_resp_ready_o;

	// only the grant owner sees the valid
	assign fetch_resp_valid_o = (state_q == ST_FETCH) && bus_resp_valid_i;
	assign data_resp_valid_o  = (state_q == ST_DATA) && bus_resp_valid_i;
	assign fetch_resp_o       = bus_resp_i;
	assign data_resp_o        = bus_resp_i;

	// grant fsm
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= ST_IDLE;
			req_valid_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (data_fire) begin
						state_q <= ST_DATA;
					end else if (fetch_fire) begin
						state_q <= ST_FETCH;
					end
				end
				default: begin
					if (resp_fire) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
			if (data_fire || fetch_fire) begin
				req_valid_q <= 1'b1;
			end else if (bus_req_ready_i) begin
				req_valid_q <= 1'b0;
			end
		end
	end

	// held request payload
	always_ff @(posedge clock) begin
		if (data_fire) begin
			req_q <= data_req_i;
		end else if (fetch_fire) begin
			req_q <= fetch_as_bus;
		end
	end

endmodule

/* verilog/bus_pkg.sv */
package bus_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// same encoding as the AXI xRESP field
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_DECERR = 2'b11
	} bus_resp_code_e;

	// ----------------------------------------
	// address views
	// ----------------------------------------
	// page and offset, as the crossbar decodes it
	typedef struct packed {
		logic [19:0] page;
		logic [11:0] offset;
	} addr_map_t;

	// word index and byte lane, as the targets index it
	typedef struct packed {
		logic [29:0] index;
		logic [1:0]  lane;
	} addr_word_t;

	typedef union packed {
		addr_map_t  map;
		addr_word_t word;
	} bus_addr_u;

	// ----------------------------------------
	// channel payloads
	// ----------------------------------------
	// instruction fetch only ever reads
	typedef struct packed {
		bus_addr_u addr;
	} fetch_req_t;

	typedef struct packed {
		bus_addr_u         addr;
		logic              write;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		bus_resp_code_e    resp;
	} bus_resp_t;

	typedef logic [7:0] uart_byte_t;

endpackage

/* verilog/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
	input  logic               clock,
	input  logic               rst_n_i,
	input  logic               req_valid_i,
	input  bus_pkg::bus_req_t  req_i,
	output logic               rsp_valid_o,
	output bus_pkg::bus_resp_t rsp_o
);

	import bus_pkg::*;

	logic [2*DATA_W-1:0] mtime_q;
	logic [DATA_W-1:0]   word_sel;
	logic [DATA_W-1:0]   rdata_q;
	logic                rsp_valid_q;

	// odd word index is the high half
	assign word_sel = req_i.addr.word.index[0] ? mtime_q[2*DATA_W-1:DATA_W]
	                                           : mtime_q[DATA_W-1:0];

	// ----------------------------------------
	// free-running machine timer
	// ----------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q     <= '0;
			rsp_valid_q <= 1'b0;
		end else begin
			mtime_q     <= mtime_q + 1'b1;
			rsp_valid_q <= req_valid_i;
		end
	end

	// writes are acked but leave mtime alone
	always_ff @(posedge clock) begin
		if (req_valid_i) begin
			rdata_q <= req_i.write ? '0 : word_sel;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = '{rdata: rdata_q, resp: RESP_OKAY};

endmodule

/* verilog/mem_fabric_top.sv */
`timescale 1ns/1ps

module mem_fabric_top (
	input  logic                clock,
	input  logic                rst_n_i,
	// fetch port
	input  logic                fetch_req_valid_i,
	input  bus_pkg::fetch_req_t fetch_req_i,
	output logic                fetch_req_ready_o,
	output logic                fetch_resp_valid_o,
	output bus_pkg::bus_resp_t  fetch_resp_o,
	input  logic                fetch_resp_ready_i,
	// data port
	input  logic                data_req_valid_i,
	input  bus_pkg::bus_req_t   data_req_i,
	output logic                data_req_ready_o,
	output logic                data_resp_valid_o,
	output bus_pkg::bus_resp_t  data_resp_o,
	input  logic                data_resp_ready_i,
	// uart byte stream
	output logic                uart_tx_valid_o,
	output bus_pkg::uart_byte_t uart_tx_byte_o,
	input  logic                uart_tx_ready_i
);

	import bus_pkg::*;

	// arbiter to crossbar
	logic      bus_req_valid;
	bus_req_t  bus_req;
	logic      bus_req_ready;
	logic      bus_resp_valid;
	bus_resp_t bus_resp;
	logic      bus_resp_ready;

	// crossbar to targets
	logic      sram_req_valid;
	bus_req_t  sram_req;
	logic      sram_rsp_valid;
	bus_resp_t sram_rsp;
	logic      uart_req_valid;
	bus_req_t  uart_req;
	logic      uart_rsp_valid;
	bus_resp_t uart_rsp;
	logic      clint_req_valid;
	bus_req_t  clint_req;
	logic      clint_rsp_valid;
	bus_resp_t clint_rsp;

	// ----------------------------------------
	// arbiter and crossbar
	// ----------------------------------------
	bus_arbiter u_bus_arbiter (
		.clock              (clock),
		.rst_n_i            (rst_n_i),
		.fetch_req_valid_i  (fetch_req_valid_i),
		.fetch_req_i        (fetch_req_i),
		.fetch_req_ready_o  (fetch_req_ready_o),
		.fetch_resp_valid_o (fetch_resp_valid_o),
		.fetch_resp_o       (fetch_resp_o),
		.fetch_resp_ready_i (fetch_resp_ready_i),
		.data_req_valid_i   (data_req_valid_i),
		.data_req_i         (data_req_i),
		.data_req_ready_o   (data_req_ready_o),
		.data_resp_valid_o  (data_resp_valid_o),
		.data_resp_o        (data_resp_o),
		.data_resp_ready_i  (data_resp_ready_i),
		.bus_req_valid_o    (bus_req_valid),
		.bus_req_o          (bus_req),
		.bus_req_ready_i    (bus_req_ready),
		.bus_resp_valid_i   (bus_resp_valid),
		.bus_resp_i         (bus_resp),
		.bus_resp_ready_o   (bus_resp_ready)
	);

	addr_xbar u_addr_xbar (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.up_req_valid_i    (bus_req_valid),
		.up_req_i          (bus_req),
		.up_req_ready_o    (bus_req_ready),
		.up_resp_valid_o   (bus_resp_valid),
		.up_resp_o         (bus_resp),
		.up_resp_ready_i   (bus_resp_ready),
		.sram_req_valid_o  (sram_req_valid),
		.sram_req_o        (sram_req),
		.sram_rsp_valid_i  (sram_rsp_valid),
		.sram_rsp_i        (sram_rsp),
		.uart_req_valid_o  (uart_req_valid),
		.uart_req_o        (uart_req),
		.uart_rsp_valid_i  (uart_rsp_valid),
		.uart_rsp_i        (uart_rsp),
		.clint_req_valid_o (clint_req_valid),
		.clint_req_o       (clint_req),
		.clint_rsp_valid_i (clint_rsp_valid),
		.clint_rsp_i       (clint_rsp)
	);

	// ----------------------------------------
	// targets
	// ----------------------------------------
	sram_target u_sram_target (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.req_valid_i (sram_req_valid),
		.req_i       (sram_req),
		.rsp_valid_o (sram_rsp_valid),
		.rsp_o       (sram_rsp)
	);

	uart_tx_target u_uart_tx_target (
		.clock           (clock),
		.rst_n_i         (rst_n_i),
		.req_valid_i     (uart_req_valid),
		.req_i           (uart_req),
		.rsp_valid_o     (uart_rsp_valid),
		.rsp_o           (uart_rsp),
		.uart_tx_valid_o (uart_tx_valid_o),
		.uart_tx_byte_o  (uart_tx_byte_o),
		.uart_tx_ready_i (uart_tx_ready_i)
	);

	clint_timer u_clint_timer (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.req_valid_i (clint_req_valid),
		.req_i       (clint_req),
		.rsp_valid_o (clint_rsp_valid),
		.rsp_o       (clint_rsp)
	);

endmodule

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;

	// ----------------------------------------
	// sram window
	// ----------------------------------------
	localparam logic [19:0] SRAM_PAGE  = 20'h80000;
	localparam int          SRAM_WORDS = 256;
	localparam int          SRAM_BYTES = SRAM_WORDS * 4;
	// word index bits that reach the array
	localparam int          SRAM_IDX_W = $clog2(SRAM_WORDS);

	// ----------------------------------------
	// io window
	// ----------------------------------------
	localparam logic [19:0] IO_PAGE      = 20'ha0000;
	// uart transmit holding register
	localparam logic [11:0] UART_OFFSET  = 12'h3f8;
	// mtime low word, high word follows at +4
	localparam logic [11:0] CLINT_OFFSET = 12'h048;

	typedef enum logic [1:0] {
		TGT_SRAM,
		TGT_UART,
		TGT_CLINT,
		TGT_NONE
	} target_sel_e;

endpackage

/* verilog/sram_target.sv */
`timescale 1ns/1ps

module sram_target (
	input  logic               clock,
	input  logic               rst_n_i,
	input  logic               req_valid_i,
	input  bus_pkg::bus_req_t  req_i,
	output logic               rsp_valid_o,
	output bus_pkg::bus_resp_t rsp_o
);

	import bus_pkg::*;
	import soc_map_pkg::*;

	logic [DATA_W-1:0]     mem_q [SRAM_WORDS];
	logic [SRAM_IDX_W-1:0] idx;
	logic [DATA_W-1:0]     merged;
	logic [DATA_W-1:0]     rdata_q;
	logic                  rsp_valid_q;

	// offset below 1 KiB is guaranteed by the decode
	assign idx = req_i.addr.word.index[SRAM_IDX_W-1:0];

	// ----------------------------------------
	// byte lane merge
	// ----------------------------------------
	always_comb begin
		merged = mem_q[idx];
		for (int b = 0; b < STRB_W; b++) begin
			if (req_i.write && req_i.strb[b]) begin
				merged[8*b +: 8] = req_i.wdata[8*b +: 8];
			end
		end
	end

	// storage and read data
	always_ff @(posedge clock) begin
		if (req_valid_i) begin
			if (req_i.write) begin
				mem_q[idx] <= merged;
			end
			rdata_q <= merged;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= req_valid_i;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = '{rdata: rdata_q, resp: RESP_OKAY};

endmodule

/* verilog/uart_tx_target.sv */
`timescale 1ns/1ps

module uart_tx_target (
	input  logic                clock,
	input  logic                rst_n_i,
	input  logic                req_valid_i,
	input  bus_pkg::bus_req_t   req_i,
	output logic                rsp_valid_o,
	output bus_pkg::bus_resp_t  rsp_o,
	output logic                uart_tx_valid_o,
	output bus_pkg::uart_byte_t uart_tx_byte_o,
	input  logic                uart_tx_ready_i
);

	import bus_pkg::*;

	logic       tx_valid_q;
	uart_byte_t tx_byte_q;
	logic       rsp_valid_q;
	logic       wr_fire;
	logic       tx_fire;

	assign wr_fire = req_valid_i && req_i.write;
	assign tx_fire = tx_valid_q && uart_tx_ready_i;

	// ----------------------------------------
	// tx holding register
	// ----------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tx_valid_q  <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			if (wr_fire) begin
				tx_valid_q <= 1'b1;
			end else if (tx_fire) begin
				tx_valid_q <= 1'b0;
			end
			// write ack waits for the byte to leave
			rsp_valid_q <= (req_valid_i && !req_i.write) || tx_fire;
		end
	end

	// only lane 0 carries the character
	always_ff @(posedge clock) begin
		if (wr_fire) begin
			tx_byte_q <= req_i.wdata[7:0];
		end
	end

	assign uart_tx_valid_o = tx_valid_q;
	assign uart_tx_byte_o  = tx_byte_q;
	assign rsp_valid_o     = rsp_valid_q;
	assign rsp_o           = '{rdata: '0, resp: RESP_OKAY};

endmodule
